// File: logic/dram_pkg.sv
package dram_pkg;

    // row address width for the single bank
    localparam int ROW_W = 12;

    // width of every wait and interval counter
    localparam int CNT_W = 8;

    // power-up wait before the first command
    localparam logic [CNT_W-1:0] T_INIT = CNT_W'(20);

    // wait state lengths, in cycles
    localparam logic [CNT_W-1:0] T_ACT  = CNT_W'(3);
    localparam logic [CNT_W-1:0] T_RD   = CNT_W'(4);
    localparam logic [CNT_W-1:0] T_WR   = CNT_W'(4);
    localparam logic [CNT_W-1:0] T_PRE  = CNT_W'(3);
    localparam logic [CNT_W-1:0] T_REF  = CNT_W'(8);

    // cycles between refresh commands
    localparam logic [CNT_W-1:0] T_REFI = CNT_W'(200);

    // issue states last one cycle, each is followed by its timed wait state
    typedef enum logic [3:0] {
        POWER_UP    = 4'd0,
        IDLE        = 4'd1,
        REFRESH     = 4'd2,
        REFRESHING  = 4'd3,
        ACTIVATE    = 4'd4,
        ACTIVATING  = 4'd5,
        READ        = 4'd6,
        READING     = 4'd7,
        WRITE       = 4'd8,
        WRITING     = 4'd9,
        PRECHARGE   = 4'd10,
        PRECHARGING = 4'd11
    } cmd_state_t;

    // class of the pending request against the open row
    typedef enum logic [1:0] {
        ROW_IDLE     = 2'b00,
        ROW_HIT      = 2'b01,
        ROW_MISS     = 2'b10,
        ROW_CONFLICT = 2'b11
    } row_stat_t;

endpackage

// File: logic/dram_ifs.sv
`timescale 1ns/1ps

// host request, command state and power-up handshake
interface command_fsm_if import dram_pkg::*; ();
    cmd_state_t       cmd_state;
    logic             init_req;
    logic             init_done;
    logic             wen;
    logic             ren;
    logic [ROW_W-1:0] row_addr;
    logic             ram_wait;

    modport cmd_fsm (
        output cmd_state,
        output init_req,
        output ram_wait,
        input  init_done,
        input  wen,
        input  ren
    );

    modport init (
        input  init_req,
        output init_done
    );

    modport row (
        input  cmd_state,
        input  wen,
        input  ren,
        input  row_addr
    );

    modport timer (
        input  cmd_state
    );
endinterface

// open-row status and the close pulse from the FSM
interface row_open_if import dram_pkg::*; ();
    row_stat_t row_stat;
    logic      row_resolve;

    modport cmd_fsm (
        input  row_stat,
        output row_resolve
    );

    modport policy (
        output row_stat,
        input  row_resolve
    );
endinterface

// wait completion strobes and the refresh request
interface timing_signals_if ();
    logic rf_req;
    logic tACT_done;
    logic tRD_done;
    logic tWR_done;
    logic tPRE_done;
    logic tREF_done;

    modport cmd_fsm (
        input  rf_req,
        input  tACT_done,
        input  tRD_done,
        input  tWR_done,
        input  tPRE_done,
        input  tREF_done
    );

    modport timer (
        output rf_req,
        output tACT_done,
        output tRD_done,
        output tWR_done,
        output tPRE_done,
        output tREF_done
    );
endinterface

// File: logic/init_sequencer.sv
`timescale 1ns/1ps

module init_sequencer import dram_pkg::*; (
    input logic          CLK,
    input logic          nRST,
    command_fsm_if.init  mycmd
);
    logic [CNT_W-1:0] init_cnt;
    logic             init_last;

    assign init_last = (init_cnt == T_INIT - 1'b1);

    // counts power-up cycles while the FSM asks for initialisation
    // init_done is sticky, so it stays set once IDLE is reached
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            init_cnt        <= '0;
            mycmd.init_done <= 1'b0;
        end else if (mycmd.init_req && !mycmd.init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_last) begin
                mycmd.init_done <= 1'b1;
            end
        end
    end

endmodule

// File: logic/timing_control.sv
`timescale 1ns/1ps

module timing_control import dram_pkg::*; (
    input logic             CLK,
    input logic             nRST,
    timing_signals_if.timer timif,
    command_fsm_if.timer    mycmd
);
    logic [CNT_W-1:0] wait_cnt;
    logic [CNT_W-1:0] refi_cnt;
    logic             wait_last;
    logic             refi_expired;

    assign wait_last    = (wait_cnt == '0);
    assign refi_expired = (refi_cnt == T_REFI - 1'b1);

    // one counter serves every wait state
    // the issue cycle loads it, so the wait state sees length-1 down to zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else begin
            case (mycmd.cmd_state)
                ACTIVATE:  wait_cnt <= T_ACT - 1'b1;
                READ:      wait_cnt <= T_RD - 1'b1;
                WRITE:     wait_cnt <= T_WR - 1'b1;
                PRECHARGE: wait_cnt <= T_PRE - 1'b1;
                REFRESH:   wait_cnt <= T_REF - 1'b1;
                default: begin
                    if (!wait_last) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // done strobes mark the last cycle of the matching wait state
    assign timif.tACT_done = wait_last && (mycmd.cmd_state == ACTIVATING);
    assign timif.tRD_done  = wait_last && (mycmd.cmd_state == READING);
    assign timif.tWR_done  = wait_last && (mycmd.cmd_state == WRITING);
    assign timif.tPRE_done = wait_last && (mycmd.cmd_state == PRECHARGING);
    assign timif.tREF_done = wait_last && (mycmd.cmd_state == REFRESHING);

    // refresh interval timer, restarted when REFRESH is issued
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refi_cnt     <= '0;
            timif.rf_req <= 1'b0;
        end else if (mycmd.cmd_state == REFRESH) begin
            refi_cnt     <= '0;
            timif.rf_req <= 1'b0;
        end else if (refi_expired) begin
            // hold the request until the FSM gets to REFRESH
            timif.rf_req <= 1'b1;
        end else begin
            refi_cnt <= refi_cnt + 1'b1;
        end
    end

endmodule

// File: logic/row_policy.sv
`timescale 1ns/1ps

module row_policy import dram_pkg::*; (
    input logic         CLK,
    input logic         nRST,
    row_open_if.policy  polif,
    command_fsm_if.row  mycmd
);
    logic [ROW_W-1:0] open_row;
    logic             row_valid;
    logic             req_present;
    logic             row_match;

    assign req_present = mycmd.wen || mycmd.ren;
    assign row_match   = (open_row == mycmd.row_addr);

    // open row address, only meaningful while row_valid is set
    always_ff @(posedge CLK) begin
        if (mycmd.cmd_state == ACTIVATE) begin
            open_row <= mycmd.row_addr;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            row_valid <= 1'b0;
        end else if (mycmd.cmd_state == ACTIVATE) begin
            row_valid <= 1'b1;
        end else if (polif.row_resolve || (mycmd.cmd_state == REFRESH)) begin
            // IDLE may go to REFRESH with a row still open and refresh closes it
            row_valid <= 1'b0;
        end
    end

    always_comb begin
        if (!req_present) begin
            polif.row_stat = ROW_IDLE;
        end else if (!row_valid) begin
            polif.row_stat = ROW_MISS;
        end else if (row_match) begin
            polif.row_stat = ROW_HIT;
        end else begin
            polif.row_stat = ROW_CONFLICT;
        end
    end

endmodule

// File: logic/command_fsm.sv
`timescale 1ns/1ps

module command_fsm import dram_pkg::*; (
    input logic            CLK,
    input logic            nRST,
    command_fsm_if.cmd_fsm mycmd,
    row_open_if.cmd_fsm    polif,
    timing_signals_if.cmd_fsm timif
);
    cmd_state_t next_state;
    logic       next_ram_wait;
    logic       host_req;
    cmd_state_t hit_cmd;

    // the finished request is still on the bus while ram_wait is low
    assign host_req = (mycmd.wen || mycmd.ren) && mycmd.ram_wait;

    // an open row on the right address goes straight to the access
    assign hit_cmd = mycmd.wen ? WRITE : READ;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mycmd.cmd_state <= POWER_UP;
            mycmd.ram_wait  <= 1'b1;
        end else begin
            mycmd.cmd_state <= next_state;
            mycmd.ram_wait  <= next_ram_wait;
        end
    end

    always_comb begin
        next_state        = mycmd.cmd_state;
        next_ram_wait     = 1'b1;
        polif.row_resolve = 1'b0;
        mycmd.init_req    = 1'b0;

        case (mycmd.cmd_state)
            POWER_UP: begin
                mycmd.init_req = 1'b1;
                if (mycmd.init_done) begin
                    next_state = IDLE;
                end
            end

            IDLE: begin
                // refresh wins over any host request
                if (timif.rf_req) begin
                    next_state = REFRESH;
                end else if (host_req) begin
                    case (polif.row_stat)
                        ROW_HIT:      next_state = hit_cmd;
                        ROW_MISS:     next_state = ACTIVATE;
                        ROW_CONFLICT: next_state = PRECHARGE;
                        default:      next_state = IDLE;
                    endcase
                end
            end

            REFRESH: begin
                next_state = REFRESHING;
            end

            REFRESHING: begin
                if (timif.tREF_done) begin
                    next_state = IDLE;
                end
            end

            ACTIVATE: begin
                next_state = ACTIVATING;
            end

            ACTIVATING: begin
                if (timif.tACT_done) begin
                    next_state = timif.rf_req ? PRECHARGE : hit_cmd;
                end
            end

            READ: begin
                next_state = timif.rf_req ? PRECHARGE : READING;
            end

            WRITE: begin
                next_state = timif.rf_req ? PRECHARGE : WRITING;
            end

            READING: begin
                if (timif.tRD_done) begin
                    next_ram_wait = 1'b0;
                    next_state    = timif.rf_req ? PRECHARGE : IDLE;
                end
            end

            WRITING: begin
                if (timif.tWR_done) begin
                    next_ram_wait = 1'b0;
                    next_state    = timif.rf_req ? PRECHARGE : IDLE;
                end
            end

            PRECHARGE: begin
                next_state = PRECHARGING;
            end

            PRECHARGING: begin
                // row is closed once the precharge wait is over
                if (timif.tPRE_done) begin
                    polif.row_resolve = 1'b1;
                    next_state        = timif.rf_req ? REFRESH : IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: logic/dram_ctrl_top.sv
`timescale 1ns/1ps

module dram_ctrl_top import dram_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             wen,
    input  logic             ren,
    input  logic [ROW_W-1:0] row_addr,
    output logic             ram_wait,
    output cmd_state_t       cmd_state
);
    command_fsm_if    cmd_if ();
    row_open_if       pol_if ();
    timing_signals_if tim_if ();

    // host request enters the shared command bundle
    assign cmd_if.wen      = wen;
    assign cmd_if.ren      = ren;
    assign cmd_if.row_addr = row_addr;

    assign ram_wait  = cmd_if.ram_wait;
    assign cmd_state = cmd_if.cmd_state;

    command_fsm i_command_fsm (
        .CLK   (CLK),
        .nRST  (nRST),
        .mycmd (cmd_if.cmd_fsm),
        .polif (pol_if.cmd_fsm),
        .timif (tim_if.cmd_fsm)
    );

    row_policy i_row_policy (
        .CLK   (CLK),
        .nRST  (nRST),
        .polif (pol_if.policy),
        .mycmd (cmd_if.row)
    );

    timing_control i_timing_control (
        .CLK   (CLK),
        .nRST  (nRST),
        .timif (tim_if.timer),
        .mycmd (cmd_if.timer)
    );

    init_sequencer i_init_sequencer (
        .CLK   (CLK),
        .nRST  (nRST),
        .mycmd (cmd_if.init)
    );

endmodule

// File: tests/dram_ctrl_assertions.sv
`timescale 1ns/1ps

module dram_ctrl_assertions import dram_pkg::*; (
    input logic       CLK,
    input logic       nRST,
    input cmd_state_t cmd_state,
    input logic       ram_wait,
    input logic       rf_req
);
    logic is_issue;

    assign is_issue = (cmd_state inside {ACTIVATE, READ, WRITE, PRECHARGE, REFRESH});

    // issue states hand over to another state after one cycle
    issue_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        is_issue |=> (cmd_state != $past(cmd_state)))
        else $error("issue state held for more than one cycle");

    wait_single_low: assert property (@(posedge CLK) disable iff (!nRST)
        !ram_wait |=> ram_wait)
        else $error("ram_wait low for two cycles running");

    // refresh has priority over a host request in IDLE
    idle_refresh: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd_state == IDLE && rf_req) |=> (cmd_state == REFRESH))
        else $error("pending refresh not taken from IDLE");

endmodule

bind command_fsm dram_ctrl_assertions i_assertions (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd_state (mycmd.cmd_state),
    .ram_wait  (mycmd.ram_wait),
    .rf_req    (timif.rf_req)
);

// File: tests/dram_ctrl_tb.sv
`timescale 1ns/1ps

module dram_ctrl_tb import dram_pkg::*; ();

    localparam int N_REQ    = 300;
    localparam int CLK_HALF = 5;
    // conflict, precharge, activate, access and the closing idle cycle
    localparam int REQ_LEN  = 5 + T_PRE + T_ACT + T_RD + T_WR;
    localparam int REF_WIN  = T_REFI + REQ_LEN;
    localparam int REQ_SLOT = REQ_LEN + 5;
    localparam int REF_CNT  = (N_REQ * REQ_SLOT) / T_REFI + 1;
    localparam int TIMEOUT  = T_INIT + 20 + N_REQ * REQ_SLOT
                              + REF_CNT * (REQ_LEN + T_REF + 2);

    logic             CLK;
    logic             nRST;
    logic             wen;
    logic             ren;
    logic [ROW_W-1:0] row_addr;
    logic             ram_wait;
    cmd_state_t       cmd_state;

    logic [31:0]      rng_state;
    logic [ROW_W-1:0] row_set [4];
    int               n_errors;
    int               n_pulses;
    int               n_refresh;
    bit               req_active;
    bit               req_write;
    bit               model_valid;
    logic [ROW_W-1:0] model_row;
    cmd_state_t       prev_state;
    logic             prev_wait;
    bit               pred_valid;
    cmd_state_t       pred_state;
    int               run_len;
    int               since_ref;

    dram_ctrl_top i_dut (
        .CLK       (CLK),
        .nRST      (nRST),
        .wen       (wen),
        .ren       (ren),
        .row_addr  (row_addr),
        .ram_wait  (ram_wait),
        .cmd_state (cmd_state)
    );

    initial begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected length of each timed wait state
    function automatic int wait_len(input cmd_state_t s);
        case (s)
            ACTIVATING:  return T_ACT;
            READING:     return T_RD;
            WRITING:     return T_WR;
            PRECHARGING: return T_PRE;
            REFRESHING:  return T_REF;
            default:     return 0;
        endcase
    endfunction

    task automatic report_mismatch(input string sig, input int exp_val, input int got_val);
        $display("ERROR %s: expected 0x%0h got 0x%0h", sig, exp_val, got_val);
        n_errors = n_errors + 1;
    endtask

    // state monitor, sampled mid-cycle where registered outputs are stable
    always @(negedge CLK) begin
        if (nRST) begin
            since_ref = since_ref + 1;
            // precharge wait just ended, bank is closed now
            if (prev_state == PRECHARGING && cmd_state != PRECHARGING) begin
                model_valid = 1'b0;
            end

            if (cmd_state != prev_state) begin
                if (wait_len(prev_state) != 0 && run_len != wait_len(prev_state)) begin
                    report_mismatch({prev_state.name(), " run length"},
                                    wait_len(prev_state), run_len);
                end
                run_len = 1;
            end else begin
                run_len = run_len + 1;
            end

            // a REFRESH taken from IDLE skips the class check
            if (prev_state == IDLE && cmd_state != IDLE && cmd_state != REFRESH) begin
                if (!pred_valid) begin
                    $display("error: the FSM left IDLE with no host request pending");
                    n_errors = n_errors + 1;
                end else if (cmd_state != pred_state) begin
                    report_mismatch("cmd_state after IDLE", pred_state, cmd_state);
                end
            end

            if (!ram_wait) begin
                n_pulses = n_pulses + 1;
                if (!prev_wait) begin
                    $display("error: ram_wait stayed low for two cycles in a row");
                    n_errors = n_errors + 1;
                end
                if (!req_active) begin
                    $display("error: ram_wait pulsed low with no request outstanding");
                    n_errors = n_errors + 1;
                end else if (prev_state != (req_write ? WRITING : READING)) begin
                    report_mismatch("cmd_state before ram_wait",
                                    req_write ? WRITING : READING, prev_state);
                end
            end

            pred_valid = 1'b0;
            if (cmd_state == IDLE && (wen || ren) && ram_wait) begin
                pred_valid = 1'b1;
                if (!model_valid) begin
                    pred_state = ACTIVATE;
                end else if (model_row == row_addr) begin
                    pred_state = wen ? WRITE : READ;
                end else begin
                    pred_state = PRECHARGE;
                end
            end

            if (cmd_state == REFRESH) begin
                n_refresh   = n_refresh + 1;
                since_ref   = 0;
                model_valid = 1'b0;
            end else if (since_ref > REF_WIN) begin
                $display("error: no REFRESH issued within %0d cycles", REF_WIN);
                n_errors  = n_errors + 1;
                since_ref = 0;
            end

            if (cmd_state == ACTIVATE) begin
                model_valid = 1'b1;
                model_row   = row_addr;
            end
        end
        prev_state = cmd_state;
        prev_wait  = ram_wait;
    end

    initial begin
        int gap;

        nRST        = 1'b0;
        wen         = 1'b0;
        ren         = 1'b0;
        row_addr    = '0;
        rng_state   = 32'd80624;
        n_errors    = 0;
        n_pulses    = 0;
        n_refresh   = 0;
        req_active  = 1'b0;
        req_write   = 1'b0;
        model_valid = 1'b0;
        model_row   = '0;
        prev_state  = POWER_UP;
        prev_wait   = 1'b1;
        pred_valid  = 1'b0;
        pred_state  = IDLE;
        run_len     = 0;
        since_ref   = 0;
        // four rows, so hits, misses and conflicts all show up
        row_set[0]  = 12'h012;
        row_set[1]  = 12'h3a5;
        row_set[2]  = 12'h7f0;
        row_set[3]  = 12'hc3c;

        @(posedge CLK);
        #1;
        if (ram_wait !== 1'b1) begin
            report_mismatch("ram_wait in reset", 1, ram_wait);
        end
        if (cmd_state !== POWER_UP) begin
            report_mismatch("cmd_state in reset", POWER_UP, cmd_state);
        end
        @(posedge CLK);
        #1;
        nRST = 1'b1;

        repeat (T_INIT) @(posedge CLK);
        #1;
        if (cmd_state != POWER_UP) begin
            report_mismatch("cmd_state before init done", POWER_UP, cmd_state);
        end
        @(posedge CLK);
        #1;
        if (cmd_state != IDLE) begin
            report_mismatch("cmd_state after init", IDLE, cmd_state);
        end

        for (int i = 0; i < N_REQ; i++) begin
            rng_state  = lcg_step(rng_state);
            gap        = rng_state[25:24];
            req_write  = rng_state[31];
            wen        = rng_state[31];
            ren        = !rng_state[31];
            row_addr   = row_set[rng_state[29:28]];
            req_active = 1'b1;
            // host holds the request until ram_wait is seen low
            @(negedge CLK);
            while (ram_wait) begin
                @(negedge CLK);
            end
            @(posedge CLK);
            #1;
            wen        = 1'b0;
            ren        = 1'b0;
            req_active = 1'b0;
            repeat (gap) begin
                @(posedge CLK);
                #1;
            end
        end

        repeat (5) @(posedge CLK);
        if (n_pulses != N_REQ) begin
            report_mismatch("ram_wait pulse count", N_REQ, n_pulses);
        end
        $display("requests %0d, ram_wait pulses %0d, refreshes %0d, errors %0d",
                 N_REQ, n_pulses, n_refresh, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge CLK);
        $display("timeout: requests not finished after %0d cycles, pulses %0d, errors %0d",
                 TIMEOUT, n_pulses, n_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: sources.f
logic/dram_pkg.sv
logic/dram_ifs.sv
logic/init_sequencer.sv
logic/timing_control.sv
logic/row_policy.sv
logic/command_fsm.sv
logic/dram_ctrl_top.sv
tests/dram_ctrl_assertions.sv
tests/dram_ctrl_tb.sv

// File: Bender.yml
package:
  name: dram_ctrl

sources:
  - logic/dram_pkg.sv
  - logic/dram_ifs.sv
  - logic/init_sequencer.sv
  - logic/timing_control.sv
  - logic/row_policy.sv
  - logic/command_fsm.sv
  - logic/dram_ctrl_top.sv
  - target: test
    files:
      - tests/dram_ctrl_assertions.sv
      - tests/dram_ctrl_tb.sv
